//--- Makefile
VERILATOR ?= verilator
TOP       ?= bt_top_tb
FILELIST  ?= bt_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bt_top.f
hw/bt_pkg.sv
hw/bt_clock.sv
hw/scan_ctrl.sv
hw/sync_correlator.sv
hw/bt_top.sv
sim/bt_top_tb.sv

//--- hw/bt_clock.sv
`timescale 1ns/1ps

module bt_clock
  import bt_pkg::*;
(
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             is_master,
  input  logic [CLK_W-1:0] time_base_offset,
  output logic             p_1us,
  output logic             slot_p,
  output logic [CLK_W-1:0] clkn,
  output logic [CLK_W-1:0] clk
);

  logic [US_CNT_W-1:0]        us_cnt;
  logic [HALF_SLOT_CNT_W-1:0] hs_cnt;
  logic                       us_last;
  logic                       hs_last;

  assign us_last = (us_cnt == US_CNT_W'(CYCLES_PER_US - 1));
  assign hs_last = (hs_cnt == HALF_SLOT_CNT_W'(CYCLES_PER_HALF_SLOT - 1));

  ////////////////////////////////////////////////////////////
  // 1 us tick
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      us_cnt <= '0;
      p_1us  <= 1'b0;
    end
    else
    begin
      us_cnt <= us_last ? '0 : us_cnt + 1'b1;
      p_1us  <= us_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // half-slot divider and CLKN
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hs_cnt <= '0;
      clkn   <= '0;
      slot_p <= 1'b0;
    end
    else
    begin
      hs_cnt <= hs_last ? '0 : hs_cnt + 1'b1;
      // slot boundary when CLKN bit 0 rolls back to 0
      slot_p <= hs_last & clkn[0];
      if (hs_last)
        clkn <= clkn + 1'b1;
    end
  end

  // slave clock runs at the master's phase, 28-bit wrap
  assign clk = is_master ? clkn : clkn + time_base_offset;

  p_1us_single_cycle: assert property (
    @(posedge clk_6M) disable iff (!rstz) p_1us |=> !p_1us
  );

endmodule

//--- hw/bt_pkg.sv
package bt_pkg;

  ////////////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////////////

  // clk_6M cycles in one microsecond
  localparam int CYCLES_PER_US = 6;
  // 312.5 us, one CLKN tick
  localparam int CYCLES_PER_HALF_SLOT = 1875;

  // divider counter widths
  localparam int US_CNT_W = 3;
  localparam int HALF_SLOT_CNT_W = 11;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // native and piconet clock
  localparam int CLK_W = 28;

  // access code and correlator
  localparam int SYNC_W = 64;
  localparam int MATCH_W = 7;
  localparam int THRESH_W = 6;

  // device address fields
  localparam int LAP_W = 24;
  localparam int UAP_W = 8;
  // low uap nibble above the lap
  localparam int HOP_ADDR_W = 28;

  // scan interval and window, in slots
  localparam int SLOT_CNT_W = 16;

  ////////////////////////////////////////////////////////////
  // link state
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_STANDBY      = 2'd0,
    ST_PAGE_SCAN    = 2'd1,
    ST_INQUIRY_SCAN = 2'd2,
    ST_CONNECTION   = 2'd3
  } link_state_t;

endpackage

//--- hw/bt_top.sv
`timescale 1ns/1ps

module bt_top
  import bt_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  is_master,
  input  logic [CLK_W-1:0]      time_base_offset,
  input  logic                  page_scan_enable,
  input  logic                  page_scan_cancel,
  input  logic                  inquiry_scan_enable,
  input  logic                  inquiry_scan_cancel,
  input  logic                  conn_detach,
  input  logic [SLOT_CNT_W-1:0] ps_interval,
  input  logic [SLOT_CNT_W-1:0] ps_window,
  input  logic [SLOT_CNT_W-1:0] is_interval,
  input  logic [SLOT_CNT_W-1:0] is_window,
  input  logic [SYNC_W-1:0]     syncword_dac,
  input  logic [SYNC_W-1:0]     syncword_giac,
  input  logic [SYNC_W-1:0]     syncword_cac,
  input  logic [UAP_W-1:0]      giac_uap,
  input  logic [UAP_W-1:0]      my_uap,
  input  logic [UAP_W-1:0]      master_uap,
  input  logic [LAP_W-1:0]      giac_lap,
  input  logic [LAP_W-1:0]      my_lap,
  input  logic [LAP_W-1:0]      master_lap,
  input  logic [THRESH_W-1:0]   corr_threshold,
  input  logic                  rx_bit,
  output logic [CLK_W-1:0]      clkn,
  output logic [CLK_W-1:0]      clk,
  output link_state_t           link_state,
  output logic                  rx_window,
  output logic [HOP_ADDR_W-1:0] hop_addr,
  output logic                  sync_hit
);

  logic              p_1us;
  logic              slot_p;
  logic [SYNC_W-1:0] access_code;

  bt_clock bt_clock_inst (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .is_master        (is_master),
    .time_base_offset (time_base_offset),
    .p_1us            (p_1us),
    .slot_p           (slot_p),
    .clkn             (clkn),
    .clk              (clk)
  );

  scan_ctrl scan_ctrl_inst (
    .clk_6M              (clk_6M),
    .rstz                (rstz),
    .slot_p              (slot_p),
    .sync_hit            (sync_hit),
    .page_scan_enable    (page_scan_enable),
    .page_scan_cancel    (page_scan_cancel),
    .inquiry_scan_enable (inquiry_scan_enable),
    .inquiry_scan_cancel (inquiry_scan_cancel),
    .conn_detach         (conn_detach),
    .ps_interval         (ps_interval),
    .ps_window           (ps_window),
    .is_interval         (is_interval),
    .is_window           (is_window),
    .syncword_dac        (syncword_dac),
    .syncword_giac       (syncword_giac),
    .syncword_cac        (syncword_cac),
    .giac_uap            (giac_uap),
    .my_uap              (my_uap),
    .master_uap          (master_uap),
    .giac_lap            (giac_lap),
    .my_lap              (my_lap),
    .master_lap          (master_lap),
    .link_state          (link_state),
    .rx_window           (rx_window),
    .access_code         (access_code),
    .hop_addr            (hop_addr)
  );

  // receive path, sampled once per microsecond
  sync_correlator sync_correlator_inst (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .p_1us          (p_1us),
    .rx_bit         (rx_bit),
    .rx_window      (rx_window),
    .access_code    (access_code),
    .corr_threshold (corr_threshold),
    .sync_hit       (sync_hit)
  );

endmodule

//--- hw/scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl
  import bt_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  slot_p,
  input  logic                  sync_hit,
  input  logic                  page_scan_enable,
  input  logic                  page_scan_cancel,
  input  logic                  inquiry_scan_enable,
  input  logic                  inquiry_scan_cancel,
  input  logic                  conn_detach,
  input  logic [SLOT_CNT_W-1:0] ps_interval,
  input  logic [SLOT_CNT_W-1:0] ps_window,
  input  logic [SLOT_CNT_W-1:0] is_interval,
  input  logic [SLOT_CNT_W-1:0] is_window,
  input  logic [SYNC_W-1:0]     syncword_dac,
  input  logic [SYNC_W-1:0]     syncword_giac,
  input  logic [SYNC_W-1:0]     syncword_cac,
  input  logic [UAP_W-1:0]      giac_uap,
  input  logic [UAP_W-1:0]      my_uap,
  input  logic [UAP_W-1:0]      master_uap,
  input  logic [LAP_W-1:0]      giac_lap,
  input  logic [LAP_W-1:0]      my_lap,
  input  logic [LAP_W-1:0]      master_lap,
  output link_state_t           link_state,
  output logic                  rx_window,
  output logic [SYNC_W-1:0]     access_code,
  output logic [HOP_ADDR_W-1:0] hop_addr
);

  link_state_t           state;
  link_state_t           next_state;
  logic [SLOT_CNT_W-1:0] slot_cnt;
  logic [SLOT_CNT_W:0]   slot_inc;
  logic [SLOT_CNT_W-1:0] cur_interval;
  logic [SLOT_CNT_W-1:0] cur_window;
  logic                  in_scan;

  ////////////////////////////////////////////////////////////
  // link state machine
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    case (state)
      ST_STANDBY:
      begin
        // page scan wins over inquiry scan
        if (page_scan_enable)
          next_state = ST_PAGE_SCAN;
        else if (inquiry_scan_enable)
          next_state = ST_INQUIRY_SCAN;
      end
      ST_PAGE_SCAN:
      begin
        if (page_scan_cancel)
          next_state = ST_STANDBY;
        else if (sync_hit)
          next_state = ST_CONNECTION;
      end
      ST_INQUIRY_SCAN:
      begin
        // a hit here is an inquiry response, no state change
        if (inquiry_scan_cancel)
          next_state = ST_STANDBY;
      end
      ST_CONNECTION:
      begin
        if (conn_detach)
          next_state = ST_STANDBY;
      end
      default:
        next_state = ST_STANDBY;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= ST_STANDBY;
    else
      state <= next_state;
  end

  assign link_state = state;

  ////////////////////////////////////////////////////////////
  // scan window
  ////////////////////////////////////////////////////////////

  assign in_scan      = (state == ST_PAGE_SCAN) || (state == ST_INQUIRY_SCAN);
  assign cur_interval = (state == ST_INQUIRY_SCAN) ? is_interval : ps_interval;
  assign cur_window   = (state == ST_INQUIRY_SCAN) ? is_window : ps_window;
  assign slot_inc     = {1'b0, slot_cnt} + 1'b1;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      slot_cnt <= '0;
    else if (next_state != state)
      slot_cnt <= '0;
    else if (in_scan && slot_p)
    begin
      // wrap once the interval is reached
      if (slot_inc >= {1'b0, cur_interval})
        slot_cnt <= '0;
      else
        slot_cnt <= slot_inc[SLOT_CNT_W-1:0];
    end
  end

  assign rx_window = (state == ST_CONNECTION) | (in_scan & (slot_cnt < cur_window));

  ////////////////////////////////////////////////////////////
  // access code and hop address by state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (state)
      ST_PAGE_SCAN:
      begin
        access_code = syncword_dac;
        hop_addr    = {my_uap[3:0], my_lap};
      end
      ST_INQUIRY_SCAN:
      begin
        access_code = syncword_giac;
        hop_addr    = {giac_uap[3:0], giac_lap};
      end
      default:
      begin
        access_code = syncword_cac;
        hop_addr    = {master_uap[3:0], master_lap};
      end
    endcase
  end

  state_legal: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    state inside {ST_STANDBY, ST_PAGE_SCAN, ST_INQUIRY_SCAN, ST_CONNECTION}
  );

endmodule

//--- hw/sync_correlator.sv
`timescale 1ns/1ps

module sync_correlator
  import bt_pkg::*;
(
  input  logic                clk_6M,
  input  logic                rstz,
  input  logic                p_1us,
  input  logic                rx_bit,
  input  logic                rx_window,
  input  logic [SYNC_W-1:0]   access_code,
  input  logic [THRESH_W-1:0] corr_threshold,
  output logic                sync_hit
);

  logic [1:0]         rx_meta;
  logic [SYNC_W-1:0]  sync_reg;
  logic               shift_d;
  logic [MATCH_W-1:0] agree_cnt;
  logic [MATCH_W-1:0] agree_min;

  ////////////////////////////////////////////////////////////
  // air bit resync and sampling
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_meta <= 2'b00;
    else
      rx_meta <= {rx_meta[0], rx_bit};
  end

  // first bit on air ends up in bit 0
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      sync_reg <= '0;
      shift_d  <= 1'b0;
    end
    else
    begin
      shift_d <= p_1us;
      if (p_1us)
        sync_reg <= {rx_meta[1], sync_reg[SYNC_W-1:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // correlator
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    agree_cnt = '0;
    for (int i = 0; i < SYNC_W; i++)
      agree_cnt = agree_cnt + MATCH_W'(sync_reg[i] ~^ access_code[i]);
  end

  // differing bits <= threshold, stated as agreeing bits
  assign agree_min = MATCH_W'(SYNC_W) - {1'b0, corr_threshold};

  // evaluated one clock after the shift
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sync_hit <= 1'b0;
    else
      sync_hit <= shift_d & rx_window & (agree_cnt >= agree_min);
  end

  hit_inside_window: assert property (
    @(posedge clk_6M) disable iff (!rstz) $rose(sync_hit) |-> $past(rx_window)
  );

endmodule

//--- sim/bt_top_tb.sv
`timescale 1ns/1ps

module bt_top_tb
  import bt_pkg::*;
();

  localparam int THRESH = 4;
  localparam int HIT_LATENCY_MAX = 12;
  localparam int CYCLES_PER_SLOT = 2 * CYCLES_PER_HALF_SLOT;
  localparam logic [SYNC_W-1:0] DAC  = 64'h4E1B_9C27_D3A5_6F08;
  localparam logic [SYNC_W-1:0] GIAC = 64'h9E8B_33C1_2A7F_5D94;
  localparam logic [SYNC_W-1:0] CAC  = 64'h73D2_A85E_0C69_B1F7;

  logic                  clk_6M;
  logic                  rstz;
  logic                  is_master;
  logic [CLK_W-1:0]      time_base_offset;
  logic                  page_scan_enable;
  logic                  page_scan_cancel;
  logic                  inquiry_scan_enable;
  logic                  inquiry_scan_cancel;
  logic                  conn_detach;
  logic [SLOT_CNT_W-1:0] ps_interval;
  logic [SLOT_CNT_W-1:0] ps_window;
  logic [SLOT_CNT_W-1:0] is_interval;
  logic [SLOT_CNT_W-1:0] is_window;
  logic [SYNC_W-1:0]     syncword_dac;
  logic [SYNC_W-1:0]     syncword_giac;
  logic [SYNC_W-1:0]     syncword_cac;
  logic [UAP_W-1:0]      giac_uap;
  logic [UAP_W-1:0]      my_uap;
  logic [UAP_W-1:0]      master_uap;
  logic [LAP_W-1:0]      giac_lap;
  logic [LAP_W-1:0]      my_lap;
  logic [LAP_W-1:0]      master_lap;
  logic [THRESH_W-1:0]   corr_threshold;
  logic                  rx_bit;
  logic [CLK_W-1:0]      clkn;
  logic [CLK_W-1:0]      clk;
  link_state_t           link_state;
  logic                  rx_window;
  logic [HOP_ADDR_W-1:0] hop_addr;
  logic                  sync_hit;

  // reference model of the link state, updated by the case tasks
  link_state_t m_state = ST_STANDBY;
  longint      m_entry = 0;
  longint      cycle_cnt = 0;
  longint      run_budget = 0;
  logic [15:0] lfsr = 16'd1081;

  bt_top bt_top_inst (.*);

  initial clk_6M = 1'b0;
  always #5 clk_6M = ~clk_6M;

  // clocks since reset release
  always @(posedge clk_6M)
  begin
    if (rstz)
      cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////
  // failure reporting and reference functions
  ////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string sig, input longint expv, input longint actv);
    $display("** Error at %0t ns: %s expected %0h, got %0h", $time, sig, expv, actv);
    end_with_failure();
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[0] ^ s[2] ^ s[3] ^ s[5];
    return {fb, s[15:1]};
  endfunction

  // slot boundaries reach the scan counter one clock after CLKN turns even
  function automatic logic window_at(input longint n);
    longint                slots;
    longint                cnt;
    logic [SLOT_CNT_W-1:0] intv;
    logic [SLOT_CNT_W-1:0] win;
    intv = (m_state == ST_INQUIRY_SCAN) ? is_interval : ps_interval;
    win  = (m_state == ST_INQUIRY_SCAN) ? is_window : ps_window;
    if (m_state == ST_STANDBY)
      return 1'b0;
    if (m_state == ST_CONNECTION)
      return 1'b1;
    slots = (n + CYCLES_PER_SLOT - 1) / CYCLES_PER_SLOT
          - (m_entry + CYCLES_PER_SLOT - 1) / CYCLES_PER_SLOT;
    cnt = (intv == 0) ? 0 : slots % longint'(intv);
    return cnt < longint'(win);
  endfunction

  function automatic logic [HOP_ADDR_W-1:0] expected_hop();
    case (m_state)
      ST_PAGE_SCAN:    return {my_uap[3:0], my_lap};
      ST_INQUIRY_SCAN: return {giac_uap[3:0], giac_lap};
      default:         return {master_uap[3:0], master_lap};
    endcase
  endfunction

  // continuous checks, away from the driving edge
  always @(negedge clk_6M)
  begin
    if (rstz)
    begin
      assert (clkn == CLK_W'(cycle_cnt / CYCLES_PER_HALF_SLOT))
      else report_mismatch("clkn", cycle_cnt / CYCLES_PER_HALF_SLOT, clkn);
      assert (link_state == m_state)
      else report_mismatch("link_state", m_state, link_state);
      assert (rx_window == window_at(cycle_cnt))
      else report_mismatch("rx_window", window_at(cycle_cnt), rx_window);
      assert (hop_addr == expected_hop())
      else report_mismatch("hop_addr", expected_hop(), hop_addr);
    end
  end

  ////////////////////////////////////////////////////////////
  // case tasks
  ////////////////////////////////////////////////////////////

  task automatic check_clock(input logic [31:0] k, input logic [31:0] offset,
                             input logic [31:0] master);
    longint           target;
    logic [CLK_W-1:0] exp_clk;
    target = longint'(k) * CYCLES_PER_HALF_SLOT;
    @(posedge clk_6M);
    is_master <= master[0];
    // a master keeps the last offset and has to ignore it
    if (!master[0])
      time_base_offset <= offset[CLK_W-1:0];
    do
      @(negedge clk_6M);
    while (cycle_cnt < target);
    if (cycle_cnt != target)
    begin
      $display("clock case for %0d half-slots comes after that time has passed", k);
      end_with_failure();
    end
    exp_clk = master[0] ? k[CLK_W-1:0] : k[CLK_W-1:0] + offset[CLK_W-1:0];
    assert (clk == exp_clk)
    else report_mismatch("clk", exp_clk, clk);
  endtask

  task automatic issue_enable(input logic [31:0] sel, input logic [31:0] intv,
                              input logic [31:0] win);
    @(posedge clk_6M);
    if (sel == 0)
    begin
      ps_interval      <= intv[SLOT_CNT_W-1:0];
      ps_window        <= win[SLOT_CNT_W-1:0];
      page_scan_enable <= 1'b1;
    end
    else
    begin
      is_interval         <= intv[SLOT_CNT_W-1:0];
      is_window           <= win[SLOT_CNT_W-1:0];
      inquiry_scan_enable <= 1'b1;
    end
    @(posedge clk_6M);
    page_scan_enable    <= 1'b0;
    inquiry_scan_enable <= 1'b0;
    // enables only count in standby
    if (m_state == ST_STANDBY)
    begin
      m_state = (sel == 0) ? ST_PAGE_SCAN : ST_INQUIRY_SCAN;
      m_entry = cycle_cnt + 1;
    end
  endtask

  task automatic issue_cancel(input logic [31:0] sel);
    @(posedge clk_6M);
    if (sel == 0)
      page_scan_cancel <= 1'b1;
    else
      inquiry_scan_cancel <= 1'b1;
    @(posedge clk_6M);
    page_scan_cancel    <= 1'b0;
    inquiry_scan_cancel <= 1'b0;
    if ((sel == 0 && m_state == ST_PAGE_SCAN) || (sel != 0 && m_state == ST_INQUIRY_SCAN))
      m_state = ST_STANDBY;
  endtask

  task automatic issue_detach();
    @(posedge clk_6M);
    conn_detach <= 1'b1;
    @(posedge clk_6M);
    conn_detach <= 1'b0;
    if (m_state == ST_CONNECTION)
      m_state = ST_STANDBY;
  endtask

  task automatic send_word(input logic [31:0] sel, input logic [31:0] want,
                           input logic [31:0] flips);
    logic [SYNC_W-1:0] word;
    logic [SYNC_W-1:0] mask;
    logic [5:0]        pos;
    logic              ready;
    logic              match;
    logic              hit_now;
    int                taken;
    int                hits;
    word  = (sel == 0) ? DAC : (sel == 1) ? GIAC : CAC;
    mask  = '0;
    taken = 0;
    hits  = 0;
    // distinct flip positions, six lfsr bits each
    while (taken < int'(flips))
    begin
      pos = '0;
      repeat (6)
      begin
        lfsr = lfsr_step(lfsr);
        pos  = {pos[4:0], lfsr[0]};
      end
      if (!mask[pos])
      begin
        mask[pos] = 1'b1;
        taken++;
      end
    end
    word = word ^ mask;
    // whole word plus latency inside one window phase
    ready = 1'b0;
    while (!ready)
    begin
      @(negedge clk_6M);
      ready = (window_at(cycle_cnt + 2) == want[0]) && (window_at(cycle_cnt + 480) == want[0]);
    end
    match = (m_state == ST_PAGE_SCAN && sel == 0) || (m_state == ST_INQUIRY_SCAN && sel == 1)
         || (m_state == ST_CONNECTION && sel == 2);
    match = match && want[0] && (int'(flips) <= THRESH);
    @(posedge clk_6M);
    for (int i = 0; i < SYNC_W - 1; i++)
    begin
      rx_bit <= word[i];
      repeat (CYCLES_PER_US)
      begin
        @(negedge clk_6M);
        assert (!sync_hit)
        else report_mismatch("sync_hit before last bit", 0, sync_hit);
        @(posedge clk_6M);
      end
    end
    rx_bit <= word[SYNC_W-1];
    for (int k = 0; k < 18; k++)
    begin
      @(negedge clk_6M);
      hit_now = sync_hit;
      if (hit_now)
        hits++;
      assert (!hit_now || k <= HIT_LATENCY_MAX)
      else
      begin
        $display("sync_hit came %0d clocks after the last bit, too late", k);
        end_with_failure();
      end
      @(posedge clk_6M);
      if (k == CYCLES_PER_US - 1)
        rx_bit <= 1'b0;
      // page scan hit moves on to connection
      if (hit_now && m_state == ST_PAGE_SCAN)
        m_state = ST_CONNECTION;
    end
    assert (hits == (match ? 1 : 0))
    else report_mismatch("sync_hit count", match ? 1 : 0, hits);
  endtask

  ////////////////////////////////////////////////////////////
  // case file and run control
  ////////////////////////////////////////////////////////////

  initial
  begin
    wait (run_budget != 0);
    #(run_budget * 10 + 20000);
    $display("watchdog expired after %0d clocks, the run is stuck", run_budget);
    end_with_failure();
  end

  initial
  begin
    string       line;
    string       op;
    string       op_q[$];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] a_q[$];
    logic [31:0] b_q[$];
    logic [31:0] c_q[$];
    longint      budget;
    longint      max_intv;
    int          fd;
    int          n;
    rstz                = 1'b0;
    is_master           = 1'b0;
    time_base_offset    = '0;
    page_scan_enable    = 1'b0;
    page_scan_cancel    = 1'b0;
    inquiry_scan_enable = 1'b0;
    inquiry_scan_cancel = 1'b0;
    conn_detach         = 1'b0;
    ps_interval         = '0;
    ps_window           = '0;
    is_interval         = '0;
    is_window           = '0;
    syncword_dac        = DAC;
    syncword_giac       = GIAC;
    syncword_cac        = CAC;
    giac_uap            = 8'h00;
    my_uap              = 8'h5C;
    master_uap          = 8'hA7;
    giac_lap            = 24'h9E8B33;
    my_lap              = 24'h3A61F2;
    master_lap          = 24'hC40D57;
    corr_threshold      = THRESH_W'(THRESH);
    rx_bit              = 1'b0;
    budget              = 0;
    max_intv            = 1;
    fd = $fopen("sim/scan_cases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open sim/scan_cases.txt");
      end_with_failure();
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23)
        continue;
      n = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d);
      if (n != 5)
      begin
        $display("malformed case line: %s", line);
        end_with_failure();
      end
      op_q.push_back(op);
      a_q.push_back(a);
      b_q.push_back(b);
      c_q.push_back(c);
      if (op == "clock")
        budget += longint'(a) * CYCLES_PER_HALF_SLOT;
      else if (op == "word")
        budget += 420 + CYCLES_PER_SLOT * (max_intv + 1);
      else
        budget += 4;
      if (op == "enable" && longint'(b) > max_intv)
        max_intv = longint'(b);
    end
    $fclose(fd);
    run_budget = budget;

    repeat (2) @(posedge clk_6M);
    rstz <= 1'b1;
    for (int i = 0; i < op_q.size(); i++)
    begin
      case (op_q[i])
        "clock":  check_clock(a_q[i], b_q[i], c_q[i]);
        "enable": issue_enable(a_q[i], b_q[i], c_q[i]);
        "cancel": issue_cancel(a_q[i]);
        "detach": issue_detach();
        "word":   send_word(a_q[i], b_q[i], c_q[i]);
        default:
        begin
          $display("unknown operation %s in case file", op_q[i]);
          end_with_failure();
        end
      endcase
    end
    repeat (4) @(posedge clk_6M);
    $display("Test OK");
    $finish;
  end

endmodule

//--- sim/scan_cases.txt
# op: clock a=half-slots b=time base offset c=is_master | enable/cancel a=0 page 1 inquiry
# enable b=interval c=window (slots) | word a=0 dac 1 giac 2 cac b=window open c=flips | hex
clock 3 0123456 0 0
clock 5 FFFFFFE 0 0
clock 8 0 1 0
enable 0 4 2 0
enable 1 6 3 0
word 0 0 0 0
word 0 1 5 0
word 0 1 4 0
word 2 1 2 0
cancel 0 0 0 0
word 2 1 0 0
detach 0 0 0 0
enable 1 3 1 0
word 1 1 3 0
word 1 0 0 0
word 0 1 0 0
word 1 1 1 0
cancel 1 0 0 0
word 1 0 0 0
enable 0 2 1 0
cancel 0 0 0 0
